//--- source/imuPkg.sv
// ############################################################
// Shared constants, types and command tables of the IMU poller
// Timing assumes a 50 MHz CLOCK_50
// Tables hold single register transactions only
// ############################################################

package imuPkg;

	// 7-bit bus addresses
	localparam logic [6:0] AccelAddr = 7'h53;
	localparam logic [6:0] GyroAddr = 7'h68;

	// 50 MHz / (4 * 31) is about 403 kHz SCL
	localparam int QuarterTicks = 31;
	localparam int QuarterWidth = $clog2(QuarterTicks);
	localparam logic [QuarterWidth-1:0] QuarterLast = QuarterWidth'(QuarterTicks - 1);

	// Delays counted in quarter ticks
	localparam logic [15:0] StartupTicks = 16'd250; // Sensor power-up margin
	localparam logic [15:0] IdleTicks = 16'd200;    // Gap between read sweeps

	localparam int InitCount = 9;
	localparam int ReadCount = 12;

	// One register transaction
	typedef struct packed {
		logic [6:0] devAddr;
		logic [7:0] regAddr;
		logic [7:0] wrData;  // Ignored on reads
		logic       read;
		logic [3:0] slot;    // Landing slot of a read byte
	} i2cCmd_t;

	typedef logic signed [15:0] axis_t;

	typedef struct packed {
		axis_t accelX;
		axis_t accelY;
		axis_t accelZ;
		axis_t gyroX;
		axis_t gyroY;
		axis_t gyroZ;
	} imuSample_t;

	// Configuration writes in bus order
	localparam i2cCmd_t InitTable [InitCount] = '{
		'{AccelAddr, 8'h2D, 8'h00, 1'b0, 4'd0}, // Power control cleared
		'{AccelAddr, 8'h2D, 8'h16, 1'b0, 4'd0},
		'{AccelAddr, 8'h2D, 8'h08, 1'b0, 4'd0}, // Measure mode
		'{AccelAddr, 8'h31, 8'h08, 1'b0, 4'd0}, // Data format
		'{AccelAddr, 8'h2C, 8'h08, 1'b0, 4'd0}, // Output rate
		'{GyroAddr, 8'h62, 8'h00, 1'b0, 4'd0},
		'{GyroAddr, 8'h21, 8'h04, 1'b0, 4'd0},
		'{GyroAddr, 8'h22, 8'h1E, 1'b0, 4'd0},
		'{GyroAddr, 8'h23, 8'h00, 1'b0, 4'd0}
	};

	// Even slot is the low byte and the next odd slot the high byte of one axis
	localparam i2cCmd_t ReadTable [ReadCount] = '{
		'{AccelAddr, 8'h32, 8'h00, 1'b1, 4'd0},
		'{AccelAddr, 8'h33, 8'h00, 1'b1, 4'd1},
		'{AccelAddr, 8'h34, 8'h00, 1'b1, 4'd2},
		'{AccelAddr, 8'h35, 8'h00, 1'b1, 4'd3},
		'{AccelAddr, 8'h36, 8'h00, 1'b1, 4'd4},
		'{AccelAddr, 8'h37, 8'h00, 1'b1, 4'd5},
		'{GyroAddr, 8'h1E, 8'h00, 1'b1, 4'd6},  // Gyro X low
		'{GyroAddr, 8'h1D, 8'h00, 1'b1, 4'd7},
		'{GyroAddr, 8'h20, 8'h00, 1'b1, 4'd8},
		'{GyroAddr, 8'h1F, 8'h00, 1'b1, 4'd9},
		'{GyroAddr, 8'h22, 8'h00, 1'b1, 4'd10},
		'{GyroAddr, 8'h21, 8'h00, 1'b1, 4'd11}
	};

endpackage

//--- source/i2cBitTimer.sv
// ############################################################
// Quarter-period tick for the bus and a loadable delay counter
// Delay of N ticks ends with one waitDone pulse
// Only one delay may run at a time
// ############################################################

module i2cBitTimer (
	input  logic        CLOCK_50,
	input  logic        rst,
	input  logic        waitLoad,
	input  logic [15:0] waitTicks,
	output logic        quarterTick,
	output logic        waitDone
);

	logic [imuPkg::QuarterWidth-1:0] preCount; // Prescaler
	logic [15:0] waitCount;                     // Remaining ticks
	logic        waitBusy;

	// Free running prescaler
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			preCount <= '0;
			quarterTick <= 1'b0;
		end
		else if (preCount == imuPkg::QuarterLast)
		begin
			preCount <= '0;
			quarterTick <= 1'b1;
		end
		else
		begin
			preCount <= preCount + 1'b1;
			quarterTick <= 1'b0;
		end
	end

	// Delay counter stepped by the tick
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			waitCount <= '0;
			waitBusy <= 1'b0;
			waitDone <= 1'b0;
		end
		else
		begin
			waitDone <= 1'b0;
			if (waitLoad)
			begin
				waitCount <= waitTicks;
				waitBusy <= 1'b1;
			end
			else if (waitBusy && quarterTick)
			begin
				if (waitCount <= 16'd1) // Zero length ends on the first tick
				begin
					waitBusy <= 1'b0;
					waitDone <= 1'b1;
				end
				else
					waitCount <= waitCount - 16'd1;
			end
		end
	end

	// Sequencer must wait for waitDone before loading again
	loadWhileIdle: assert property (@(posedge CLOCK_50) disable iff (rst)
		waitLoad |-> !waitBusy)
		else $error("waitLoad while a delay is running");

endmodule

//--- source/i2cByteEngine.sv
// ############################################################
// Runs one register write or register read as I2C master
// Each bit, start, restart and stop takes four quarter ticks
// cmd must stay stable while busy is high
// Open-drain outputs where 1 pulls the line low
// ############################################################

module i2cByteEngine (
	input  logic            CLOCK_50,
	input  logic            rst,
	input  logic            quarterTick,
	input  logic            start,
	input  imuPkg::i2cCmd_t cmd,
	input  logic            sdaIn,
	output logic            busy,
	output logic            done,
	output logic            nack,
	output logic [7:0]      rdData,
	output logic            sclLow,
	output logic            sdaLow
);

	typedef enum logic [3:0] {
		segIdle,
		segStart,
		segAddrW,   // Address with write bit
		segReg,
		segData,
		segRestart,
		segAddrR,   // Address with read bit
		segRead,
		segStop
	} seg_t;

	seg_t       seg;
	seg_t       nextSeg;
	logic [1:0] phase;    // Quarter within the current bit
	logic [3:0] bitCnt;   // 8 is the ACK bit
	logic       nackFlag; // Sticky for the transaction
	logic [7:0] rxShift;
	logic [7:0] txByte;
	logic       sdaDrive;
	logic       lastBit;
	logic       bitSeg;

	assign busy = (seg != segIdle);
	assign rdData = rxShift;
	assign lastBit = (bitCnt == 4'd8);
	assign bitSeg = seg inside {segAddrW, segReg, segData, segAddrR, segRead};

	// Byte sent in the current segment
	always_comb
	begin
		case (seg)
			segAddrW: txByte = {cmd.devAddr, 1'b0};
			segReg:   txByte = cmd.regAddr;
			segData:  txByte = cmd.wrData;
			segAddrR: txByte = {cmd.devAddr, 1'b1};
			default:  txByte = 8'hFF;
		endcase
	end

	// SDA level set while SCL is low
	always_comb
	begin
		case (seg)
			segStop:  sdaDrive = 1'b1; // Low so the stop can rise
			segStart, segRestart, segRead: sdaDrive = 1'b0;
			default:  sdaDrive = !lastBit && !txByte[3'd7 - bitCnt[2:0]]; // MSB first, ACK released
		endcase
	end

	// Segment after the current one ends
	always_comb
	begin
		case (seg)
			segStart:   nextSeg = segAddrW;
			segAddrW:   nextSeg = nackFlag ? segStop : segReg;
			segReg:     nextSeg = nackFlag ? segStop : (cmd.read ? segRestart : segData);
			segData:    nextSeg = segStop;
			segRestart: nextSeg = segAddrR;
			segAddrR:   nextSeg = nackFlag ? segStop : segRead;
			segRead:    nextSeg = segStop;
			default:    nextSeg = segIdle;
		endcase
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			seg <= segIdle;
			phase <= 2'd0;
			bitCnt <= 4'd0;
			nackFlag <= 1'b0;
			sclLow <= 1'b0;
			sdaLow <= 1'b0;
			done <= 1'b0;
			nack <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			nack <= 1'b0;
			if (seg == segIdle)
			begin
				if (start)
				begin
					seg <= segStart;
					phase <= 2'd0;
					bitCnt <= 4'd0;
					nackFlag <= 1'b0;
				end
			end
			else if (quarterTick)
			begin
				phase <= phase + 2'd1;
				case (phase)
					2'd0: sdaLow <= sdaDrive; // SCL is low here
					2'd1: sclLow <= 1'b0;     // SCL rises
					2'd2:
					begin
						// Middle of SCL high
						if (seg == segStart || seg == segRestart)
							sdaLow <= 1'b1;   // Start condition
						else if (seg == segStop)
							sdaLow <= 1'b0;   // Stop condition
						else if (lastBit && seg != segRead)
							nackFlag <= nackFlag | sdaIn;
					end
					default:
					begin
						if (seg == segStop)
						begin
							seg <= segIdle;   // Bus left released
							done <= 1'b1;
							nack <= nackFlag;
						end
						else
						begin
							sclLow <= 1'b1;
							if (bitSeg && !lastBit)
								bitCnt <= bitCnt + 4'd1;
							else
							begin
								bitCnt <= 4'd0;
								seg <= nextSeg;
							end
						end
					end
				endcase
			end
		end
	end

	// Read data sampled at the SCL high midpoint
	always_ff @(posedge CLOCK_50)
	begin
		if (quarterTick && phase == 2'd2 && seg == segRead && !lastBit)
			rxShift <= {rxShift[6:0], sdaIn};
	end

	noStartAtDone: assert property (@(posedge CLOCK_50) disable iff (rst)
		!(done && start))
		else $error("start issued in the done cycle");

	// SDA may move under a high SCL only as start or stop
	sdaStableHigh: assert property (@(posedge CLOCK_50) disable iff (rst)
		(sdaLow != $past(sdaLow) && !sclLow) |-> seg inside {segStart, segRestart, segStop})
		else $error("SDA changed while SCL high");

endmodule

//--- source/imuSequencer.sv
// ############################################################
// Walks the configuration table once and the read table forever
// A NACK aborts the sweep and forces configuration after idle
// One transaction in flight at a time
// ############################################################

module imuSequencer (
	input  logic            CLOCK_50,
	input  logic            rst,
	input  logic            busy,
	input  logic            done,
	input  logic            nack,
	input  logic            waitDone,
	output logic            start,
	output logic            storeByte,
	output logic            commit,
	output logic            busError,
	output logic            waitLoad,
	output logic [15:0]     waitTicks,
	output imuPkg::i2cCmd_t cmd,
	output logic [3:0]      slot
);

	typedef enum logic [1:0] {
		startupWait,
		configure,
		readSweep,
		idleWait
	} seqState_t;

	seqState_t  state;
	logic [3:0] index;      // Table position
	logic       issued;     // Start sent and done pending
	logic       needConfig; // Set by a NACK
	logic       waitArm;    // Delay still to be loaded
	logic       lastInit;
	logic       lastRead;

	assign lastInit = (index == 4'(imuPkg::InitCount - 1));
	assign lastRead = (index == 4'(imuPkg::ReadCount - 1));

	assign cmd = (state == configure) ? imuPkg::InitTable[index] : imuPkg::ReadTable[index];
	assign slot = cmd.slot;
	assign waitTicks = (state == startupWait) ? imuPkg::StartupTicks : imuPkg::IdleTicks;
	assign storeByte = (state == readSweep) && done && !nack; // Byte lands on this edge

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			state <= startupWait;
			index <= 4'd0;
			issued <= 1'b0;
			needConfig <= 1'b0;
			waitArm <= 1'b1;
			start <= 1'b0;
			commit <= 1'b0;
			busError <= 1'b0;
			waitLoad <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			commit <= 1'b0;
			busError <= 1'b0;
			waitLoad <= 1'b0;
			case (state)
				startupWait, idleWait:
				begin
					if (waitArm)
					begin
						waitLoad <= 1'b1;
						waitArm <= 1'b0;
					end
					else if (waitDone)
					begin
						state <= (state == startupWait || needConfig) ? configure : readSweep;
						needConfig <= 1'b0;
						index <= 4'd0;
					end
				end
				default:
				begin
					if (!issued && !busy)
					begin
						start <= 1'b1;
						issued <= 1'b1;
					end
					else if (done)
					begin
						issued <= 1'b0;
						if (nack)
						begin
							busError <= 1'b1;  // Sweep dropped
							needConfig <= 1'b1;
							state <= idleWait;
							waitArm <= 1'b1;
						end
						else if (state == configure && lastInit)
						begin
							state <= readSweep; // Straight into the first sweep
							index <= 4'd0;
						end
						else if (state == readSweep && lastRead)
						begin
							commit <= 1'b1;
							state <= idleWait;
							waitArm <= 1'b1;
						end
						else
							index <= index + 4'd1;
					end
				end
			endcase
		end
	end

	// Engine must be idle whenever a transaction is launched
	startWhenIdle: assert property (@(posedge CLOCK_50) disable iff (rst)
		start |-> !busy)
		else $error("start while byte engine busy");

endmodule

//--- source/sampleStore.sv
// ############################################################
// Byte slots for one sweep and the published sample
// sample changes only in the dataValid cycle
// ############################################################

module sampleStore (
	input  logic               CLOCK_50,
	input  logic               rst,
	input  logic               storeByte,
	input  logic [3:0]         slot,
	input  logic [7:0]         rdData,
	input  logic               commit,
	output imuPkg::imuSample_t sample,
	output logic               dataValid
);

	logic [7:0] slotMem [imuPkg::ReadCount]; // Low byte in even slots

	always_ff @(posedge CLOCK_50)
	begin
		if (storeByte)
			slotMem[slot] <= rdData;
	end

	// All six axes move together
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			sample <= '0;
			dataValid <= 1'b0;
		end
		else
		begin
			dataValid <= commit;
			if (commit)
			begin
				sample.accelX <= {slotMem[1], slotMem[0]};
				sample.accelY <= {slotMem[3], slotMem[2]};
				sample.accelZ <= {slotMem[5], slotMem[4]};
				sample.gyroX <= {slotMem[7], slotMem[6]};
				sample.gyroY <= {slotMem[9], slotMem[8]};
				sample.gyroZ <= {slotMem[11], slotMem[10]};
			end
		end
	end

	// Commit follows the last slot write directly
	commitAfterLast: assert property (@(posedge CLOCK_50) disable iff (rst)
		commit |-> $past(storeByte && slot == 4'(imuPkg::ReadCount - 1)))
		else $error("commit without slot 11 write");

endmodule

//--- source/imuInterface.sv
// ############################################################
// IMU poller top for accelerometer 53h and gyroscope 68h
// sclLow and sdaLow pull the lines low and need external pull-ups
// sdaIn is the resolved SDA line
// No back-pressure on dataValid
// ############################################################

module imuInterface (
	input  logic               CLOCK_50,
	input  logic               rst,
	input  logic               sdaIn,
	output logic               sclLow,
	output logic               sdaLow,
	output imuPkg::imuSample_t sample,
	output logic               dataValid,
	output logic               busError
);

	logic            quarterTick;
	logic            waitLoad;
	logic            waitDone;
	logic [15:0]     waitTicks;
	logic            start;
	logic            busy;
	logic            done;
	logic            nack;
	logic [7:0]      rdData;
	imuPkg::i2cCmd_t cmd;
	logic            storeByte;
	logic            commit;
	logic [3:0]      slot;

	i2cBitTimer bitTimer (
		.CLOCK_50    (CLOCK_50),
		.rst         (rst),
		.waitLoad    (waitLoad),
		.waitTicks   (waitTicks),
		.quarterTick (quarterTick),
		.waitDone    (waitDone)
	);

	i2cByteEngine byteEngine (
		.CLOCK_50    (CLOCK_50),
		.rst         (rst),
		.quarterTick (quarterTick),
		.start       (start),
		.cmd         (cmd),
		.sdaIn       (sdaIn),
		.busy        (busy),
		.done        (done),
		.nack        (nack),
		.rdData      (rdData),
		.sclLow      (sclLow),
		.sdaLow      (sdaLow)
	);

	imuSequencer sequencer (
		.CLOCK_50  (CLOCK_50),
		.rst       (rst),
		.busy      (busy),
		.done      (done),
		.nack      (nack),
		.waitDone  (waitDone),
		.start     (start),
		.storeByte (storeByte),
		.commit    (commit),
		.busError  (busError),
		.waitLoad  (waitLoad),
		.waitTicks (waitTicks),
		.cmd       (cmd),
		.slot      (slot)
	);

	sampleStore store (
		.CLOCK_50  (CLOCK_50),
		.rst       (rst),
		.storeByte (storeByte),
		.slot      (slot),
		.rdData    (rdData),
		.commit    (commit),
		.sample    (sample),
		.dataValid (dataValid)
	);

endmodule

//--- sim/sensorModel.sv
// ############################################################
// Behavioral I2C slave for accelerometer 53h and gyroscope 68h
// One register per transaction, no clock stretching
// Writes are only logged, register contents come from the testbench
// injectNack rising arms a NACK of the next valid address byte
// ############################################################

module sensorModel (
	input  logic scl,
	input  logic sda,
	input  logic injectNack,
	output logic sdaLow
);

	typedef enum {busIdle, rxByte, ackOut, txByte, ackIn} mode_t;

	logic [7:0] accelRegs [256];
	logic [7:0] gyroRegs [256];
	logic [6:0] logDev [64];    // Write log
	logic [7:0] logReg [64];
	logic [7:0] logData [64];
	int         logCount;
	int         readCount;      // Read addresses accepted
	int         firstReadLog;   // logCount at the first read, -1 before
	mode_t      mode;
	logic [7:0] shiftReg;
	logic [7:0] txData;
	logic [7:0] regPtr;
	int         bitCnt;
	int         byteIdx;
	logic       gyroSel;
	logic       isRead;
	logic       nackArmed;

	initial
	begin
		sdaLow = 1'b0;
		mode = busIdle;
		logCount = 0;
		readCount = 0;
		firstReadLog = -1;
		nackArmed = 1'b0;
		for (int i = 0; i < 256; i++)
		begin
			accelRegs[i] = 8'h00;
			gyroRegs[i] = 8'h00;
		end
	end

	always @(posedge injectNack)
		nackArmed = 1'b1;

	// Start or repeated start
	always @(negedge sda)
	begin
		if (scl === 1'b1)
		begin
			mode = rxByte;
			bitCnt = 0;
			byteIdx = 0;
			sdaLow = 1'b0;
		end
	end

	always @(posedge sda)
	begin
		if (scl === 1'b1)
			mode = busIdle; // Stop
	end

	always @(posedge scl)
	begin
		case (mode)
			rxByte:
			begin
				shiftReg = {shiftReg[6:0], sda};
				bitCnt++;
			end
			txByte: bitCnt++;
			ackIn: mode = busIdle; // Master NACK ends the read
			default: ;
		endcase
	end

	task automatic acceptByte();
		logic match;
		match = (shiftReg[7:1] == 7'h53) || (shiftReg[7:1] == 7'h68);
		if (byteIdx == 0)
		begin
			if (match && !nackArmed)
			begin
				gyroSel = (shiftReg[7:1] == 7'h68);
				isRead = shiftReg[0];
				if (isRead)
				begin
					readCount++;
					if (firstReadLog < 0)
						firstReadLog = logCount;
				end
				sdaLow = 1'b1;
				mode = ackOut;
			end
			else
			begin
				if (match)
					nackArmed = 1'b0; // Injected NACK used up
				mode = busIdle;
			end
		end
		else if (byteIdx == 1)
		begin
			regPtr = shiftReg;
			sdaLow = 1'b1;
			mode = ackOut;
		end
		else if (byteIdx == 2 && !isRead)
		begin
			logDev[logCount] = gyroSel ? 7'h68 : 7'h53;
			logReg[logCount] = regPtr;
			logData[logCount] = shiftReg;
			logCount++;
			sdaLow = 1'b1;
			mode = ackOut;
		end
		else
			mode = busIdle; // Extra bytes get a NACK
	endtask

	// Data and ACK change only while SCL is low
	always @(negedge scl)
	begin
		case (mode)
			rxByte:
				if (bitCnt == 8)
					acceptByte();
			ackOut:
			begin
				sdaLow = 1'b0;
				byteIdx++;
				bitCnt = 0;
				if (isRead && byteIdx == 1)
				begin
					txData = gyroSel ? gyroRegs[regPtr] : accelRegs[regPtr];
					sdaLow = !txData[7];
					mode = txByte;
				end
				else
					mode = rxByte;
			end
			txByte:
			begin
				if (bitCnt == 8)
				begin
					sdaLow = 1'b0; // Release for the master ACK bit
					mode = ackIn;
				end
				else
					sdaLow = !txData[7 - bitCnt];
			end
			default: ;
		endcase
	end

endmodule

//--- sim/imuInterfaceTb.sv
// ############################################################
// Testbench for imuInterface with two sensor model devices
// Concurrent assertions do the checking
// Stimulus only steers the run through config, sweeps and NACK
// ############################################################

module imuInterfaceTb;

	localparam int Timeout = 200000; // Cycles per wait

	logic               CLOCK_50;
	logic               rst;
	logic               injectNack;
	logic               sclLow;
	logic               sdaLow;
	logic               modelSdaLow;
	logic               sclLine;
	logic               sdaLine;
	logic               dataValid;
	logic               busError;
	logic               resetSeen;
	logic               checkValues;
	logic               nackInjected;
	logic               sclPrev;
	logic               sdaPrev;
	int                 sclPulses;    // SCL rises since the last start or stop
	logic [31:0]        lfsrState;
	int                 cfgTarget;    // Writes needed before the next sample
	imuPkg::imuSample_t sample;
	imuPkg::imuSample_t expectSample;

	assign sclLine = !sclLow;                  // Only the master drives SCL
	assign sdaLine = !(sdaLow || modelSdaLow); // Wired AND with pull-up

	imuInterface DUT (
		.CLOCK_50  (CLOCK_50),
		.rst       (rst),
		.sdaIn     (sdaLine),
		.sclLow    (sclLow),
		.sdaLow    (sdaLow),
		.sample    (sample),
		.dataValid (dataValid),
		.busError  (busError)
	);

	sensorModel sensor (
		.scl        (sclLine),
		.sda        (sdaLine),
		.injectNack (injectNack),
		.sdaLow     (modelSdaLow)
	);

	initial CLOCK_50 = 1'b0;
	always #20 CLOCK_50 = !CLOCK_50;

	always @(posedge CLOCK_50)
	begin
		resetSeen <= 1'b1;
		if (busError)
			cfgTarget <= sensor.logCount + imuPkg::InitCount;
		sclPrev <= sclLine;
		sdaPrev <= sdaLine;
		if (rst)
			sclPulses <= 0;
		else if (sclLine && sclPrev && sdaLine != sdaPrev)
			sclPulses <= 0;             // Start or stop opens a new frame
		else if (sclLine && !sclPrev)
			sclPulses <= sclPulses + 1;
	end

	task automatic failRun();
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic [22:0] expectedWrite(int n);
		imuPkg::i2cCmd_t c;
		c = imuPkg::InitTable[n % imuPkg::InitCount];
		return {c.devAddr, c.regAddr, c.wrData};
	endfunction

	function automatic logic [22:0] loggedWrite(int n);
		return {sensor.logDev[n], sensor.logReg[n], sensor.logData[n]};
	endfunction

	resetState: assert property (@(posedge CLOCK_50)
		(rst && resetSeen) || $fell(rst) |->
		!sclLow && !sdaLow && !dataValid && !busError && sample == 96'd0)
		else
		begin
			$display("CHECK FAILED reset: expected 0, actual scl %b sda %b valid %b err %b sample %h",
				sclLow, sdaLow, dataValid, busError, sample);
			failRun();
		end

	// Each new log entry continues the configuration sequence
	configOrder: assert property (@(posedge CLOCK_50) disable iff (rst)
		sensor.logCount != $past(sensor.logCount) |->
		loggedWrite(sensor.logCount - 1) == expectedWrite(sensor.logCount - 1))
		else
		begin
			$display("CHECK FAILED config: expected %h, actual %h",
				expectedWrite(sensor.logCount - 1), loggedWrite(sensor.logCount - 1));
			failRun();
		end

	configBeforeRead: assert property (@(posedge CLOCK_50) disable iff (rst)
		sensor.firstReadLog >= 0 |-> sensor.firstReadLog == imuPkg::InitCount)
		else
		begin
			$display("CHECK FAILED first read: expected %0d writes, actual %0d",
				imuPkg::InitCount, sensor.firstReadLog);
			failRun();
		end

	sampleValue: assert property (@(posedge CLOCK_50) disable iff (rst)
		dataValid && checkValues |-> sample == expectSample)
		else
		begin
			$display("CHECK FAILED sample: expected %h, actual %h", expectSample, sample);
			failRun();
		end

	sampleAtomic: assert property (@(posedge CLOCK_50) disable iff (rst)
		!dataValid |-> $stable(sample))
		else
		begin
			$display("CHECK FAILED atomic: expected %h, actual %h", $past(sample), sample);
			failRun();
		end

	// A dropped sweep needs a fresh configuration first
	reconfigured: assert property (@(posedge CLOCK_50) disable iff (rst)
		dataValid |-> sensor.logCount >= cfgTarget)
		else
		begin
			$display("CHECK FAILED recovery: expected %0d writes, actual %0d",
				cfgTarget, sensor.logCount);
			failRun();
		end

	errorOnlyOnNack: assert property (@(posedge CLOCK_50) disable iff (rst)
		busError |-> nackInjected)
		else
		begin
			$display("busError raised although every byte was acknowledged");
			failRun();
		end

	// SDA under a high SCL moves only from the master and only at a frame edge
	// Start from idle at pulse 0, restart and stop one pulse after a whole byte
	busProtocol: assert property (@(posedge CLOCK_50) disable iff (rst)
		sclLine && $past(sclLine) && sdaLine != $past(sdaLine) |->
		modelSdaLow == $past(modelSdaLow) &&
		(sclPulses % 9 == 1 || (sclPulses == 0 && !sdaLine)))
		else
		begin
			$display("SDA changed while SCL was high outside a start or stop condition");
			failRun();
		end

	function automatic logic [31:0] lfsrNext(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
	endfunction

	task automatic randomByte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			b = {b[6:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState); // One step per bit
		end
	endtask

	task automatic scrambleRegs();
		logic [7:0] b;
		for (int r = 8'h32; r <= 8'h37; r++)
		begin
			randomByte(b);
			sensor.accelRegs[r] = b;
		end
		for (int r = 8'h1D; r <= 8'h22; r++)
		begin
			randomByte(b);
			sensor.gyroRegs[r] = b;
		end
	endtask

	// High register times 256 plus low register for each axis
	task automatic updateExpected();
		expectSample.accelX = {sensor.accelRegs[8'h33], sensor.accelRegs[8'h32]};
		expectSample.accelY = {sensor.accelRegs[8'h35], sensor.accelRegs[8'h34]};
		expectSample.accelZ = {sensor.accelRegs[8'h37], sensor.accelRegs[8'h36]};
		expectSample.gyroX = {sensor.gyroRegs[8'h1D], sensor.gyroRegs[8'h1E]};
		expectSample.gyroY = {sensor.gyroRegs[8'h1F], sensor.gyroRegs[8'h20]};
		expectSample.gyroZ = {sensor.gyroRegs[8'h21], sensor.gyroRegs[8'h22]};
	endtask

	task automatic reload();
		scrambleRegs();
		updateExpected();
	endtask

	task automatic stepCycle();
		@(posedge CLOCK_50);
		#5;
	endtask

	task automatic waitForValid();
		int n;
		n = 0;
		stepCycle();
		while (!dataValid && n < Timeout)
		begin
			stepCycle();
			n++;
		end
		if (!dataValid)
		begin
			$display("Timed out waiting for dataValid");
			failRun();
		end
		else
			stepCycle(); // Pulse is checked on this edge
	endtask

	task automatic waitForError();
		int n;
		n = 0;
		stepCycle();
		while (!busError && n < Timeout)
		begin
			stepCycle();
			n++;
		end
		if (!busError)
		begin
			$display("Timed out waiting for busError");
			failRun();
		end
	endtask

	task automatic waitForReads(int count);
		int n;
		int target;
		n = 0;
		target = sensor.readCount + count;
		while (sensor.readCount < target && n < Timeout)
		begin
			stepCycle();
			n++;
		end
		if (sensor.readCount < target)
		begin
			$display("Timed out waiting for sensor reads");
			failRun();
		end
	endtask

	initial
	begin
		rst = 1'b1;
		injectNack = 1'b0;
		resetSeen = 1'b0;
		checkValues = 1'b1;
		nackInjected = 1'b0;
		cfgTarget = 0;
		lfsrState = 32'hdde6;
		repeat (10) stepCycle();
		reload();                  // Model memories are cleared at time 0
		rst = 1'b0;

		// Plain sweeps
		waitForValid();
		reload();
		waitForValid();
		reload();

		// Registers move in the middle of a sweep
		waitForReads(6);
		checkValues = 1'b0;
		scrambleRegs();
		waitForValid();
		reload();
		checkValues = 1'b1;

		// NACK on a read address
		waitForValid();
		reload();
		waitForReads(3);
		nackInjected = 1'b1;
		injectNack = 1'b1;
		stepCycle();
		injectNack = 1'b0;
		waitForError();
		waitForValid();
		repeat (20) stepCycle();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- files.f
source/imuPkg.sv
source/i2cBitTimer.sv
source/i2cByteEngine.sv
source/imuSequencer.sv
source/sampleStore.sv
source/imuInterface.sv
sim/sensorModel.sv
sim/imuInterfaceTb.sv

//--- Makefile
# Verilator build for the IMU poller testbench

TOP = imuInterfaceTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
